//--- logic/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// lanes per cycle
`define ISSUE_WIDTH 2

// data and address width
`define DATA_WIDTH 32

// cycles the multiplier keeps the stage paused
`define MUL_CYCLES 2

`endif

//--- logic/pipeline_pkg.sv
`include "ex_defines.svh"

package pipeline_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_JAL,
        ALU_MUL
    } alu_op_t;

    // one lane from dispatch
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        alu_op_t                alu_op;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] imm;
        logic [4:0]             rd;
        logic                   we;
        logic                   pred_taken;
        logic [`DATA_WIDTH-1:0] pred_target;
    } dispatch_ex_t;

    // one lane towards the memory stage
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        logic [4:0]             rd;
        logic                   we;
        logic [`DATA_WIDTH-1:0] result;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        logic                   taken;
        logic [`DATA_WIDTH-1:0] target;
    } branch_update_t;

    typedef struct packed {
        logic                   we;
        logic [4:0]             rd;
        logic [`DATA_WIDTH-1:0] data;
    } fwd_t;

    // branches and jal change control flow
    function automatic logic is_ctrl_op(alu_op_t op);
        return op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_JAL};
    endfunction

endpackage

//--- logic/alu_core.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_core
    import pipeline_pkg::*;
(
    input  alu_op_t                op_i,
    input  logic [`DATA_WIDTH-1:0] a_i,
    input  logic [`DATA_WIDTH-1:0] b_i,
    output logic [`DATA_WIDTH-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits
    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SLT: begin
                result_o = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result_o = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
            end
            // link value from the pc and 4 fed by the lane
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_JAL: begin
                result_o = a_i + b_i;
            end
            // mul is not handled here
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- logic/branch_resolve.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module branch_resolve
    import pipeline_pkg::*;
(
    input  dispatch_ex_t           lane_i,
    output logic                   mispredict_o,
    output logic [`DATA_WIDTH-1:0] target_o,
    output branch_update_t         update_o
);

    logic                   is_ctrl;
    logic                   taken;
    logic [`DATA_WIDTH-1:0] jump_pc;
    logic [`DATA_WIDTH-1:0] seq_pc;

    assign is_ctrl = lane_i.valid && is_ctrl_op(lane_i.alu_op);

    always_comb begin
        case (lane_i.alu_op)
            ALU_BEQ: taken = lane_i.a == lane_i.b;
            ALU_BNE: taken = lane_i.a != lane_i.b;
            ALU_BLT: taken = $signed(lane_i.a) < $signed(lane_i.b);
            ALU_BGE: taken = $signed(lane_i.a) >= $signed(lane_i.b);
            ALU_JAL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump_pc = lane_i.pc + lane_i.imm;
    assign seq_pc  = lane_i.pc + `DATA_WIDTH'(4);

    // wrong direction, or taken to a different place
    assign mispredict_o = is_ctrl &&
                          ((taken != lane_i.pred_taken) ||
                           (taken && (jump_pc != lane_i.pred_target)));

    assign target_o = taken ? jump_pc : seq_pc;

    assign update_o.valid  = is_ctrl;
    assign update_o.pc     = lane_i.pc;
    assign update_o.taken  = taken;
    assign update_o.target = jump_pc;

endmodule

//--- logic/main_ex.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module main_ex
    import pipeline_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  dispatch_ex_t           lane_i,
    input  logic                   flush_i,
    output logic                   pause_o,
    output logic                   mispredict_o,
    output logic [`DATA_WIDTH-1:0] target_o,
    output branch_update_t         update_o,
    output ex_mem_t                lane_o
);

    localparam int CHUNK = `DATA_WIDTH / `MUL_CYCLES;
    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic                   is_mul;
    logic                   is_ctrl;
    logic [`DATA_WIDTH-1:0] alu_a;
    logic [`DATA_WIDTH-1:0] alu_b;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic [CNT_W-1:0]       mul_cnt;
    logic                   mul_done;
    int                     base_shift;
    logic [`DATA_WIDTH-1:0] b_chunk;
    logic [`DATA_WIDTH-1:0] partial;
    logic [`DATA_WIDTH-1:0] acc;

    assign is_mul  = lane_i.valid && (lane_i.alu_op == ALU_MUL);
    assign is_ctrl = is_ctrl_op(lane_i.alu_op);

    // branches compute the link value pc + 4
    assign alu_a = is_ctrl ? lane_i.pc : lane_i.a;
    assign alu_b = is_ctrl ? `DATA_WIDTH'(4) : lane_i.b;

    alu_core u_alu (
        .op_i     (lane_i.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_resolve u_branch (
        .lane_i       (lane_i),
        .mispredict_o (mispredict_o),
        .target_o     (target_o),
        .update_o     (update_o)
    );

    // one chunk of the multiplier bits per cycle
    assign base_shift = int'(mul_cnt) * CHUNK;
    assign b_chunk    = lane_i.b >> base_shift;

    always_comb begin
        partial = '0;
        for (int j = 0; j < CHUNK; j++) begin
            if (b_chunk[j]) begin
                partial = partial + (lane_i.a << (j + base_shift));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            mul_cnt  <= '0;
            mul_done <= 1'b0;
        end else if (mul_done) begin
            // product is shown for one cycle only
            mul_done <= 1'b0;
        end else if (is_mul) begin
            if (mul_cnt == CNT_W'(`MUL_CYCLES - 1)) begin
                mul_cnt  <= '0;
                mul_done <= 1'b1;
            end else begin
                mul_cnt <= mul_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_mul && !mul_done) begin
            acc <= (mul_cnt == '0) ? partial : acc + partial;
        end
    end

    assign pause_o = is_mul && !mul_done;

    assign lane_o.valid  = lane_i.valid;
    assign lane_o.pc     = lane_i.pc;
    assign lane_o.rd     = lane_i.rd;
    assign lane_o.we     = lane_i.we;
    assign lane_o.result = is_mul ? acc : alu_result;

endmodule

//--- logic/deputy_ex.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module deputy_ex
    import pipeline_pkg::*;
(
    input  dispatch_ex_t           lane_i,
    output logic                   mispredict_o,
    output logic [`DATA_WIDTH-1:0] target_o,
    output branch_update_t         update_o,
    output ex_mem_t                lane_o
);

    logic                   is_ctrl;
    logic [`DATA_WIDTH-1:0] alu_a;
    logic [`DATA_WIDTH-1:0] alu_b;
    logic [`DATA_WIDTH-1:0] alu_result;

    assign is_ctrl = is_ctrl_op(lane_i.alu_op);
    assign alu_a   = is_ctrl ? lane_i.pc : lane_i.a;
    assign alu_b   = is_ctrl ? `DATA_WIDTH'(4) : lane_i.b;

    alu_core u_alu (
        .op_i     (lane_i.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_resolve u_branch (
        .lane_i       (lane_i),
        .mispredict_o (mispredict_o),
        .target_o     (target_o),
        .update_o     (update_o)
    );

    // a mul is dropped since this lane has no multiplier
    assign lane_o.valid  = lane_i.valid && (lane_i.alu_op != ALU_MUL);
    assign lane_o.pc     = lane_i.pc;
    assign lane_o.rd     = lane_i.rd;
    assign lane_o.we     = lane_i.we;
    assign lane_o.result = alu_result;

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module execute
    import pipeline_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   pause_i,
    input  dispatch_ex_t           ex_lane_i [`ISSUE_WIDTH],
    output branch_update_t         bpu_update_o [`ISSUE_WIDTH],
    output fwd_t                   fwd_o [`ISSUE_WIDTH],
    output logic                   pause_ex_o,
    output logic                   branch_flush_o,
    output logic [`DATA_WIDTH-1:0] branch_target_o,
    output ex_mem_t                mem_lane_o [`ISSUE_WIDTH]
);

    ex_mem_t                 ex_o [`ISSUE_WIDTH];
    logic [`ISSUE_WIDTH-1:0] mispredict;
    logic [`DATA_WIDTH-1:0]  target [`ISSUE_WIDTH];
    logic                    pause_main;

    main_ex u_main (
        .clk          (clk),
        .reset_i      (reset_i),
        .lane_i       (ex_lane_i[0]),
        .flush_i      (flush_i),
        .pause_o      (pause_main),
        .mispredict_o (mispredict[0]),
        .target_o     (target[0]),
        .update_o     (bpu_update_o[0]),
        .lane_o       (ex_o[0])
    );

    deputy_ex u_deputy (
        .lane_i       (ex_lane_i[1]),
        .mispredict_o (mispredict[1]),
        .target_o     (target[1]),
        .update_o     (bpu_update_o[1]),
        .lane_o       (ex_o[1])
    );

    // only the main lane can pause
    assign pause_ex_o = pause_main;

    // lane 0 is older and its target wins
    assign branch_flush_o  = |mispredict;
    assign branch_target_o = mispredict[0] ? target[0] : target[1];

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_fwd
        assign fwd_o[i].we   = ex_o[i].valid && ex_o[i].we;
        assign fwd_o[i].rd   = ex_o[i].rd;
        assign fwd_o[i].data = ex_o[i].result;
    end

    // flush wins over pause
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                mem_lane_o[i] <= '0;
            end
        end else if (!pause_i) begin
            mem_lane_o[0] <= ex_o[0];
            // younger lane is on the wrong path
            mem_lane_o[1] <= mispredict[0] ? '0 : ex_o[1];
        end
    end

endmodule

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module pipe_ctrl (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   pause_ex_i,
    input  logic                   branch_flush_i,
    input  logic [`DATA_WIDTH-1:0] branch_target_i,
    output logic                   pause_o,
    output logic                   flush_o,
    output logic                   redirect_valid_o,
    output logic [`DATA_WIDTH-1:0] redirect_pc_o
);

    logic redirect_take;

    assign pause_o = stall_i || pause_ex_i;
    assign flush_o = flush_i;

    // mispredict counts only once the lane is accepted
    assign redirect_take = branch_flush_i && !pause_o && !flush_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= redirect_take;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_take) begin
            redirect_pc_o <= branch_target_i;
        end
    end

endmodule

//--- logic/ex_stage_top.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_top
    import pipeline_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  dispatch_ex_t           ex_lane_i [`ISSUE_WIDTH],
    output logic                   pause_o,
    output logic                   redirect_valid_o,
    output logic [`DATA_WIDTH-1:0] redirect_pc_o,
    output ex_mem_t                mem_lane_o [`ISSUE_WIDTH],
    output fwd_t                   fwd_o [`ISSUE_WIDTH],
    output branch_update_t         bpu_update_o [`ISSUE_WIDTH]
);

    logic                   flush;
    logic                   pause_ex;
    logic                   branch_flush;
    logic [`DATA_WIDTH-1:0] branch_target;

    pipe_ctrl u_ctrl (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .pause_ex_i       (pause_ex),
        .branch_flush_i   (branch_flush),
        .branch_target_i  (branch_target),
        .pause_o          (pause_o),
        .flush_o          (flush),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    execute u_execute (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush),
        .pause_i         (pause_o),
        .ex_lane_i       (ex_lane_i),
        .bpu_update_o    (bpu_update_o),
        .fwd_o           (fwd_o),
        .pause_ex_o      (pause_ex),
        .branch_flush_o  (branch_flush),
        .branch_target_o (branch_target),
        .mem_lane_o      (mem_lane_o)
    );

endmodule

//--- tb/ex_stage_checker.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_checker
    import pipeline_pkg::*;
(
    input logic                   clk,
    input logic                   reset_i,
    input logic                   stall_i,
    input logic                   flush_i,
    input dispatch_ex_t           ex_lane_i [`ISSUE_WIDTH],
    input logic                   pause_o,
    input logic                   redirect_valid_o,
    input logic [`DATA_WIDTH-1:0] redirect_pc_o,
    input ex_mem_t                mem_lane_o [`ISSUE_WIDTH],
    input fwd_t                   fwd_o [`ISSUE_WIDTH],
    input branch_update_t         bpu_update_o [`ISSUE_WIDTH]
);

    int                     fail_count = 0;
    int                     pause_run = 0;
    logic                   br [`ISSUE_WIDTH];
    logic                   tk [`ISSUE_WIDTH];
    logic                   mis [`ISSUE_WIDTH];
    logic [`DATA_WIDTH-1:0] nxt [`ISSUE_WIDTH];
    logic [`DATA_WIDTH-1:0] res [`ISSUE_WIDTH];
    logic                   fwd_we [`ISSUE_WIDTH];
    logic                   pause_exp;
    logic                   clr_q;
    logic                   acc_q;
    logic                   hold_q;
    logic                   redir_q;
    logic [`DATA_WIDTH-1:0] redir_pc_q;
    ex_mem_t                exp_q [`ISSUE_WIDTH];
    ex_mem_t                prev_q [`ISSUE_WIDTH];

    function automatic logic [`DATA_WIDTH-1:0] op_rule(alu_op_t op, logic [`DATA_WIDTH-1:0] a,
                                                       logic [`DATA_WIDTH-1:0] b,
                                                       logic [`DATA_WIDTH-1:0] pc);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU: return (a < b) ? 1 : 0;
            ALU_MUL: return a * b;
            // link value for branches and jal
            default: return pc + 4;
        endcase
    endfunction

    function automatic logic taken_rule(alu_op_t op, logic [`DATA_WIDTH-1:0] a,
                                        logic [`DATA_WIDTH-1:0] b);
        case (op)
            ALU_BEQ: return a == b;
            ALU_BNE: return a != b;
            ALU_BLT: return $signed(a) < $signed(b);
            ALU_BGE: return $signed(a) >= $signed(b);
            ALU_JAL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            br[i]  = ex_lane_i[i].valid && (ex_lane_i[i].alu_op inside
                     {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_JAL});
            tk[i]  = taken_rule(ex_lane_i[i].alu_op, ex_lane_i[i].a, ex_lane_i[i].b);
            nxt[i] = tk[i] ? ex_lane_i[i].pc + ex_lane_i[i].imm : ex_lane_i[i].pc + 4;
            mis[i] = br[i] && ((tk[i] != ex_lane_i[i].pred_taken) ||
                     (tk[i] && (nxt[i] != ex_lane_i[i].pred_target)));
            res[i] = op_rule(ex_lane_i[i].alu_op, ex_lane_i[i].a, ex_lane_i[i].b,
                             ex_lane_i[i].pc);
            fwd_we[i] = ex_lane_i[i].valid && ex_lane_i[i].we &&
                        !(i == 1 && ex_lane_i[i].alu_op == ALU_MUL);
        end
        // stall, or a mul in lane 0 for exactly MUL_CYCLES cycles
        pause_exp = stall_i || (ex_lane_i[0].valid && ex_lane_i[0].alu_op == ALU_MUL &&
                                pause_run < `MUL_CYCLES);
    end

    // reference model of the execute-to-memory register
    always_ff @(posedge clk) begin
        clr_q      <= reset_i || flush_i;
        acc_q      <= !reset_i && !flush_i && !pause_o;
        hold_q     <= !reset_i && !flush_i && pause_o;
        redir_q    <= !reset_i && !flush_i && !pause_o && (mis[0] || mis[1]);
        redir_pc_q <= mis[0] ? nxt[0] : nxt[1];
        prev_q     <= mem_lane_o;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            exp_q[i].pc     <= ex_lane_i[i].pc;
            exp_q[i].rd     <= ex_lane_i[i].rd;
            exp_q[i].we     <= ex_lane_i[i].we;
            exp_q[i].result <= res[i];
        end
        exp_q[0].valid <= ex_lane_i[0].valid;
        exp_q[1].valid <= ex_lane_i[1].valid && (ex_lane_i[1].alu_op != ALU_MUL) && !mis[0];
        pause_run      <= (pause_o && !stall_i) ? pause_run + 1 : 0;
    end

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_lane
        a_clear: assert property (@(posedge clk) disable iff (reset_i)
            clr_q |-> !mem_lane_o[i].valid)
            else begin
                fail_count++;
                $error("mem_lane_o[%0d] still valid after flush or reset at %0t", i, $time);
            end
        a_valid: assert property (@(posedge clk) disable iff (reset_i)
            acc_q |-> mem_lane_o[i].valid == exp_q[i].valid)
            else begin
                fail_count++;
                $error("mismatch at %0t: mem_lane_o[%0d].valid expected %b got %b", $time, i,
                       $sampled(exp_q[i].valid), $sampled(mem_lane_o[i].valid));
            end
        a_result: assert property (@(posedge clk) disable iff (reset_i)
            (acc_q && exp_q[i].valid) |-> mem_lane_o[i].result == exp_q[i].result)
            else begin
                fail_count++;
                $error("mismatch at %0t: mem_lane_o[%0d].result expected %h got %h", $time, i,
                       $sampled(exp_q[i].result), $sampled(mem_lane_o[i].result));
            end
        a_pc_rd: assert property (@(posedge clk) disable iff (reset_i)
            (acc_q && exp_q[i].valid) |->
                (mem_lane_o[i].pc == exp_q[i].pc && mem_lane_o[i].rd == exp_q[i].rd &&
                 mem_lane_o[i].we == exp_q[i].we))
            else begin
                fail_count++;
                $error("mismatch at %0t: mem_lane_o[%0d] {pc,rd,we} expected %h got %h",
                       $time, i, $sampled({exp_q[i].pc, exp_q[i].rd, exp_q[i].we}),
                       $sampled({mem_lane_o[i].pc, mem_lane_o[i].rd, mem_lane_o[i].we}));
            end
        a_hold: assert property (@(posedge clk) disable iff (reset_i)
            hold_q |-> mem_lane_o[i] == prev_q[i])
            else begin
                fail_count++;
                $error("mem_lane_o[%0d] changed while the stage was paused at %0t", i, $time);
            end
        a_bpu: assert property (@(posedge clk) disable iff (reset_i)
            bpu_update_o[i].valid == br[i] && (!br[i] || (bpu_update_o[i].taken == tk[i] &&
            bpu_update_o[i].pc == ex_lane_i[i].pc &&
            bpu_update_o[i].target == ex_lane_i[i].pc + ex_lane_i[i].imm)))
            else begin
                fail_count++;
                $error("mismatch at %0t: bpu_update_o[%0d] {valid,taken,pc,target} expected %h got %h",
                       $time, i, $sampled({br[i], tk[i], ex_lane_i[i].pc,
                                           ex_lane_i[i].pc + ex_lane_i[i].imm}),
                       $sampled({bpu_update_o[i].valid, bpu_update_o[i].taken,
                                 bpu_update_o[i].pc, bpu_update_o[i].target}));
            end
        a_fwd: assert property (@(posedge clk) disable iff (reset_i)
            fwd_o[i].we == fwd_we[i] && (!fwd_we[i] || ex_lane_i[i].alu_op == ALU_MUL ||
            (fwd_o[i].rd == ex_lane_i[i].rd && fwd_o[i].data == res[i])))
            else begin
                fail_count++;
                $error("mismatch at %0t: fwd_o[%0d] {we,rd,data} expected %h got %h", $time, i,
                       $sampled({fwd_we[i], ex_lane_i[i].rd, res[i]}),
                       $sampled({fwd_o[i].we, fwd_o[i].rd, fwd_o[i].data}));
            end
    end

    a_redirect: assert property (@(posedge clk) disable iff (reset_i)
        redirect_valid_o == redir_q && (!redir_q || redirect_pc_o == redir_pc_q))
        else begin
            fail_count++;
            $error("mismatch at %0t: redirect_valid_o/redirect_pc_o expected %b/%h got %b/%h",
                   $time, $sampled(redir_q), $sampled(redir_pc_q),
                   $sampled(redirect_valid_o), $sampled(redirect_pc_o));
        end

    // a mul holds the stage for exactly MUL_CYCLES
    a_pause: assert property (@(posedge clk) disable iff (reset_i)
        pause_o == pause_exp)
        else begin
            fail_count++;
            $error("mismatch at %0t: pause_o expected %b got %b", $time,
                   $sampled(pause_exp), $sampled(pause_o));
        end

endmodule

bind ex_stage_top ex_stage_checker chk0 (.*);

//--- tb/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_stage
    import pipeline_pkg::*;
();

    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 20;
    // a send can wait on random stalls
    localparam int MAX_CYCLES = (N_RANDOM + N_DIRECTED) * 8 + 100;

    logic                   clk;
    logic                   reset_i;
    logic                   stall_i;
    logic                   flush_i;
    dispatch_ex_t           ex_lane_i [`ISSUE_WIDTH];
    logic                   pause_o;
    logic                   redirect_valid_o;
    logic [`DATA_WIDTH-1:0] redirect_pc_o;
    ex_mem_t                mem_lane_o [`ISSUE_WIDTH];
    fwd_t                   fwd_o [`ISSUE_WIDTH];
    branch_update_t         bpu_update_o [`ISSUE_WIDTH];
    integer                 seed;
    logic                   stall_en;
    int                     errors;

    ex_stage_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic dispatch_ex_t make_lane(alu_op_t op, logic [31:0] a, logic [31:0] b,
                                               logic [31:0] pc, logic [31:0] imm,
                                               logic pt, logic [31:0] ptgt);
        dispatch_ex_t l;
        l.valid       = 1'b1;
        l.pc          = pc;
        l.alu_op      = op;
        l.a           = a;
        l.b           = b;
        l.imm         = imm;
        l.rd          = 5'd7;
        l.we          = 1'b1;
        l.pred_taken  = pt;
        l.pred_target = ptgt;
        return l;
    endfunction

    function automatic dispatch_ex_t rand_lane(logic allow_mul);
        dispatch_ex_t l;
        logic [31:0]  r;
        r             = $random(seed);
        l.valid       = r[2:0] != 3'd0;
        l.alu_op      = alu_op_t'({$random(seed)} % (allow_mul ? 15 : 14));
        l.pc          = $random(seed) & 32'hffff_fffc;
        l.a           = $random(seed);
        // equal operands now and then so beq and bge see both outcomes
        l.b           = r[3] ? l.a : $random(seed);
        l.imm         = $random(seed) & 32'h0000_0ffc;
        l.rd          = r[12:8];
        l.we          = r[4];
        l.pred_taken  = r[5];
        l.pred_target = r[6] ? l.pc + l.imm : $random(seed);
        return l;
    endfunction

    // starts on a rising edge and returns on the edge that accepts the lanes
    task automatic send(input dispatch_ex_t l0, input dispatch_ex_t l1);
        logic done;
        ex_lane_i[0] <= l0;
        ex_lane_i[1] <= l1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = !pause_o;
            @(posedge clk);
            stall_i <= stall_en && ({$random(seed)} % 4 == 0);
        end
    endtask

    task automatic flush_under_stall();
        stall_i <= 1'b1;
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        stall_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic apply_reset();
        reset_i <= 1'b1;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    initial begin
        seed         = 26541;
        reset_i      = 1'b1;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        stall_en     = 1'b0;
        ex_lane_i[0] = '0;
        ex_lane_i[1] = '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // lane 0 taken but predicted not taken
        send(make_lane(ALU_BEQ, 5, 5, 32'h100, 32'h40, 1'b0, 0),
             make_lane(ALU_ADD, 3, 4, 32'h104, 0, 1'b0, 0));
        // lane 0 correct and lane 1 blt mispredicts
        send(make_lane(ALU_BNE, 1, 2, 32'h200, 32'h10, 1'b1, 32'h210),
             make_lane(ALU_BLT, -5, 3, 32'h204, 32'h20, 1'b0, 0));
        // both mispredict and lane 0 falls through
        send(make_lane(ALU_BGE, -1, 1, 32'h300, 32'h80, 1'b1, 32'h380),
             make_lane(ALU_JAL, 0, 0, 32'h304, 32'h100, 1'b0, 0));
        // jal to a wrong predicted target
        send(make_lane(ALU_JAL, 0, 0, 32'h400, 32'h24, 1'b1, 32'h999),
             make_lane(ALU_SUB, 9, 4, 32'h404, 0, 1'b0, 0));
        send(rand_lane(1'b0), rand_lane(1'b1));

        for (int k = 0; k < 4; k++) begin
            send(make_lane(ALU_MUL, $random(seed), $random(seed), 32'h500 + 8 * k, 0, 1'b0, 0),
                 rand_lane(1'b0));
        end

        send(rand_lane(1'b0), rand_lane(1'b1));
        flush_under_stall();
        send(rand_lane(1'b0), rand_lane(1'b1));
        apply_reset();

        stall_en = 1'b1;
        repeat (N_RANDOM) send(rand_lane(1'b0), rand_lane(1'b1));
        stall_en = 1'b0;
        stall_i <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);

        errors = dut0.chk0.fail_count;
        $display("errors: assertion failures %0d, timeouts 0", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 20);
        $display("watchdog expired after %0d cycles, stimulus did not finish", MAX_CYCLES);
        $display("errors: assertion failures %0d, timeouts 1", dut0.chk0.fail_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/pipeline_pkg.sv
logic/alu_core.sv
logic/branch_resolve.sv
logic/main_ex.sv
logic/deputy_ex.sv
logic/execute.sv
logic/pipe_ctrl.sv
logic/ex_stage_top.sv
tb/ex_stage_checker.sv
tb/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_stage \
    -f filelist.f -o sim_ex_stage || exit 1

./obj_dir/sim_ex_stage +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "TESTS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
